// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_NOP = 4'h7, // Unused encoding, carried by pipeline bubbles.
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LLB = 4'hA,
		OP_LHB = 4'hB,
		OP_BR  = 4'hC,
		OP_HLT = 4'hF
	} opcode_e;

	typedef enum logic [2:0] {
		CC_NE     = 3'd0,
		CC_EQ     = 3'd1,
		CC_ALWAYS = 3'd7
	} ccode_e;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef enum logic [1:0] {
		FWD_REG      = 2'd0,
		FWD_FROM_WB  = 2'd1,
		FWD_FROM_MEM = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		logic [15:0] instr;
		logic [15:0] pc2;
	} ifid_t;

	typedef struct packed {
		opcode_e     op;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  rt;
		logic [15:0] rdata1;
		logic [15:0] rdata2;
		logic [15:0] imm;
		logic [8:0]  br_off;
		ccode_e      ccode;
		logic [15:0] pc2;
	} idex_t;

	typedef struct packed {
		opcode_e     op;
		logic [3:0]  rd;
		logic [15:0] result;
		logic [15:0] st_data;
		logic [15:0] addr;
	} exmem_t;

	// Load data joins in write-back straight from the data memory port.
	typedef struct packed {
		opcode_e     op;
		logic [3:0]  rd;
		logic [15:0] result;
	} memwb_t;

	localparam ifid_t IFID_BUBBLE = '{instr: {OP_NOP, 12'h000}, pc2: 16'h0000};
	localparam idex_t IDEX_BUBBLE = '{
		op: OP_NOP, rd: 4'd0, rs: 4'd0, rt: 4'd0,
		rdata1: 16'h0000, rdata2: 16'h0000, imm: 16'h0000,
		br_off: 9'd0, ccode: CC_NE, pc2: 16'h0000
	};
	localparam exmem_t EXMEM_BUBBLE = '{
		op: OP_NOP, rd: 4'd0, result: 16'h0000, st_data: 16'h0000, addr: 16'h0000
	};
	localparam memwb_t MEMWB_BUBBLE = '{op: OP_NOP, rd: 4'd0, result: 16'h0000};

	function automatic logic writes_reg(input opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_XOR, OP_LW, OP_LLB, OP_LHB};
	endfunction

	function automatic logic is_load(input opcode_e op);
		return op == OP_LW;
	endfunction

endpackage

// ==== src/rf_if.sv ====
`timescale 1ns/1ps

interface rf_if;
	logic [3:0]  raddr1;
	logic [3:0]  raddr2;
	logic [15:0] rdata1;
	logic [15:0] rdata2;
	logic [3:0]  waddr;
	logic [15:0] wdata;
	logic        we;

	modport dec_mp (output raddr1, output raddr2, input rdata1, input rdata2);

	modport rf_mp (
		input raddr1, input raddr2, output rdata1, output rdata2,
		input waddr, input wdata, input we
	);

	modport wb_mp (output waddr, output wdata, output we);
endinterface

// ==== src/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
	parameter type PAYLOAD_T = logic [15:0],
	parameter PAYLOAD_T BUBBLE = '0
) (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     hold_i,
	input  logic     flush_i,
	input  PAYLOAD_T d_i,
	output PAYLOAD_T q_o,
	output logic     valid_o
);

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			q_o     <= BUBBLE; // Opcode becomes the no-op encoding.
			valid_o <= 1'b0;
		end else if (!hold_i) begin
			q_o     <= d_i;
			valid_o <= 1'b1;
		end
	end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst_i,
	rf_if.rf_mp rf
);

	logic [15:0] regs [16];

	function automatic logic [15:0] read_port(input logic [3:0] addr, input logic [15:0] stored,
			input logic we, input logic [3:0] waddr, input logic [15:0] wdata);
		if (addr == 4'd0) begin
			return 16'h0000;
		end
		if (we && waddr == addr) begin
			return wdata; // Same-cycle write is visible to the reader.
		end
		return stored;
	endfunction

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (rf.we && rf.waddr != 4'd0) begin
			regs[rf.waddr] <= rf.wdata;
		end
	end

	assign rf.rdata1 = read_port(rf.raddr1, regs[rf.raddr1], rf.we, rf.waddr, rf.wdata);
	assign rf.rdata2 = read_port(rf.raddr2, regs[rf.raddr2], rf.we, rf.waddr, rf.wdata);

endmodule

// ==== src/decode.sv ====
`timescale 1ns/1ps

module decode (
	input  cpu_pkg::ifid_t ifid_i,
	input  logic           ifid_valid_i,
	rf_if.dec_mp           rf,
	output cpu_pkg::idex_t idex_o,
	output logic [3:0]     rs_o,
	output logic [3:0]     rt_o,
	output logic           halt_seen_o
);
	import cpu_pkg::*;

	opcode_e     op;
	logic [3:0]  rs;
	logic [3:0]  rt;
	logic [15:0] imm;
	logic [15:0] instr;

	assign instr = ifid_i.instr;
	assign op    = ifid_valid_i ? opcode_e'(instr[15:12]) : OP_NOP;

	// ********************
	// Source fields and immediate.
	always_comb begin
		rs  = 4'd0;
		rt  = 4'd0;
		imm = 16'h0000;
		case (op)
			OP_ADD, OP_SUB, OP_XOR: begin
				rs = instr[7:4];
				rt = instr[3:0];
			end
			OP_LW, OP_SW: begin
				rs  = instr[7:4]; // Base register.
				rt  = instr[11:8]; // Data register.
				imm = {{12{instr[3]}}, instr[3:0]};
			end
			OP_LLB: begin
				rs  = instr[11:8]; // Old rd value, merged in execute.
				imm = {8'h00, instr[7:0]};
			end
			OP_LHB: begin
				rs  = instr[11:8];
				imm = {instr[7:0], 8'h00};
			end
			default: begin
				rs = 4'd0;
			end
		endcase
	end

	assign rf.raddr1 = rs;
	assign rf.raddr2 = rt;
	assign rs_o      = rs;
	assign rt_o      = rt;

	// ********************
	// Payload for the execute stage.
	always_comb begin
		idex_o.op     = op;
		idex_o.rd     = instr[11:8];
		idex_o.rs     = rs;
		idex_o.rt     = rt;
		idex_o.rdata1 = rf.rdata1;
		idex_o.rdata2 = rf.rdata2;
		idex_o.imm    = imm;
		idex_o.br_off = instr[8:0];
		idex_o.ccode  = ccode_e'(instr[11:9]);
		idex_o.pc2    = ifid_i.pc2;
	end

	assign halt_seen_o = (op == OP_HLT); // Stops fetch from this cycle on.

endmodule

// ==== src/hazard_fwd.sv ====
`timescale 1ns/1ps

module hazard_fwd (
	input  logic [3:0]        dec_rs_i,
	input  logic [3:0]        dec_rt_i,
	input  cpu_pkg::opcode_e  ex_op_i,
	input  logic [3:0]        ex_rd_i,
	input  logic [3:0]        ex_rs_i,
	input  logic [3:0]        ex_rt_i,
	input  cpu_pkg::opcode_e  mem_op_i,
	input  logic [3:0]        mem_rd_i,
	input  cpu_pkg::opcode_e  wb_op_i,
	input  logic [3:0]        wb_rd_i,
	output logic              stall_o,
	output cpu_pkg::fwd_sel_e fwd_a_o,
	output cpu_pkg::fwd_sel_e fwd_b_o
);
	import cpu_pkg::*;

	function automatic fwd_sel_e pick(input logic [3:0] src, input opcode_e mem_op,
			input logic [3:0] mem_rd, input opcode_e wb_op, input logic [3:0] wb_rd);
		if (src == 4'd0) begin
			return FWD_REG;
		end
		// A load in memory has no data yet, the stall keeps it out of reach.
		if (writes_reg(mem_op) && !is_load(mem_op) && mem_rd == src) begin
			return FWD_FROM_MEM;
		end
		if (writes_reg(wb_op) && wb_rd == src) begin
			return FWD_FROM_WB;
		end
		return FWD_REG;
	endfunction

	assign stall_o = is_load(ex_op_i) && ex_rd_i != 4'd0 &&
		(ex_rd_i == dec_rs_i || ex_rd_i == dec_rt_i);

	assign fwd_a_o = pick(ex_rs_i, mem_op_i, mem_rd_i, wb_op_i, wb_rd_i);
	assign fwd_b_o = pick(ex_rt_i, mem_op_i, mem_rd_i, wb_op_i, wb_rd_i);

endmodule

// ==== src/execute.sv ====
`timescale 1ns/1ps

module execute (
	input  logic              clk,
	input  logic              rst_i,
	input  cpu_pkg::idex_t    idex_i,
	input  logic              idex_valid_i,
	input  cpu_pkg::fwd_sel_e fwd_a_i,
	input  cpu_pkg::fwd_sel_e fwd_b_i,
	input  logic [15:0]       mem_fwd_i,
	input  logic [15:0]       wb_fwd_i,
	output cpu_pkg::exmem_t   exmem_o,
	output logic              br_taken_o,
	output logic [15:0]       br_target_o
);
	import cpu_pkg::*;

	logic [15:0] op_a;
	logic [15:0] op_b;
	logic [15:0] sum;
	logic [15:0] diff;
	logic [15:0] result;
	logic        ovf;
	logic        flags_we;
	logic        cond_met;
	flags_t      flags_q;

	function automatic logic [15:0] fwd_mux(input fwd_sel_e sel, input logic [15:0] reg_val,
			input logic [15:0] mem_val, input logic [15:0] wb_val);
		case (sel)
			FWD_FROM_MEM: return mem_val;
			FWD_FROM_WB:  return wb_val;
			default:      return reg_val;
		endcase
	endfunction

	assign op_a = fwd_mux(fwd_a_i, idex_i.rdata1, mem_fwd_i, wb_fwd_i);
	assign op_b = fwd_mux(fwd_b_i, idex_i.rdata2, mem_fwd_i, wb_fwd_i);
	assign sum  = op_a + op_b;
	assign diff = op_a - op_b;

	// ********************
	// ALU.
	always_comb begin
		result   = 16'h0000;
		ovf      = 1'b0;
		flags_we = 1'b0;
		case (idex_i.op)
			OP_ADD: begin
				result   = sum;
				ovf      = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
				flags_we = 1'b1;
			end
			OP_SUB: begin
				result   = diff;
				ovf      = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);
				flags_we = 1'b1;
			end
			OP_XOR: begin
				result   = op_a ^ op_b;
				flags_we = 1'b1;
			end
			OP_LLB: result = (op_a & 16'hFF00) | idex_i.imm;
			OP_LHB: result = (op_a & 16'h00FF) | idex_i.imm;
			default: result = 16'h0000;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			flags_q <= '0;
		end else if (idex_valid_i && flags_we) begin
			flags_q <= '{z: (result == 16'h0000), v: ovf, n: result[15]};
		end
	end

	// ********************
	// Branch resolution.
	always_comb begin
		case (idex_i.ccode)
			CC_NE:     cond_met = !flags_q.z;
			CC_EQ:     cond_met = flags_q.z;
			CC_ALWAYS: cond_met = 1'b1;
			default:   cond_met = 1'b0;
		endcase
	end

	assign br_taken_o  = idex_valid_i && idex_i.op == OP_BR && cond_met;
	assign br_target_o = idex_i.pc2 + {{6{idex_i.br_off[8]}}, idex_i.br_off, 1'b0};

	always_comb begin
		exmem_o.op      = idex_valid_i ? idex_i.op : OP_NOP;
		exmem_o.rd      = idex_i.rd;
		exmem_o.result  = result;
		exmem_o.st_data = op_b;
		exmem_o.addr    = op_a + idex_i.imm; // Word address for LW and SW.
	end

endmodule

// ==== src/imem.sv ====
`timescale 1ns/1ps

module imem #(
	parameter int IMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          we_i,
	input  logic [$clog2(IMEM_WORDS)-1:0] waddr_i,
	input  logic [15:0]                   wdata_i,
	input  logic [15:0]                   addr_i,
	output logic [15:0]                   data_o
);

	localparam int AW = $clog2(IMEM_WORDS);

	logic [15:0] mem [IMEM_WORDS];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	assign data_o = mem[addr_i[AW:1]]; // PC is a byte address.

endmodule

// ==== src/cpu.sv ====
`timescale 1ns/1ps

module cpu #(
	parameter int IMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          imem_we_i,
	input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
	input  logic [15:0]                   imem_data_i,
	output logic [15:0]                   dmem_addr_o,
	output logic [15:0]                   dmem_wdata_o,
	output logic                          dmem_we_o,
	output logic                          dmem_re_o,
	input  logic [15:0]                   dmem_rdata_i,
	output logic [15:0]                   pc_o,
	output logic                          hlt_o
);
	import cpu_pkg::*;

	logic [15:0] pc_q;
	logic [15:0] pc_plus2;
	logic [15:0] instr;
	ifid_t       ifid_d;
	ifid_t       ifid_q;
	logic        ifid_valid;
	idex_t       idex_d;
	idex_t       idex_q;
	logic        idex_valid;
	exmem_t      exmem_d;
	exmem_t      exmem_q;
	logic        exmem_valid;
	memwb_t      memwb_d;
	memwb_t      memwb_q;
	logic        memwb_valid;
	logic [3:0]  dec_rs;
	logic [3:0]  dec_rt;
	logic        halt_seen;
	logic        halt_q;
	logic        fetch_stop;
	logic        stall;
	fwd_sel_e    fwd_a;
	fwd_sel_e    fwd_b;
	logic        br_taken;
	logic [15:0] br_target;
	logic [15:0] wb_value;
	logic        hlt_q;

	rf_if rf_bus ();

	// ********************
	// Fetch.
	assign pc_plus2   = pc_q + 16'd2;
	assign fetch_stop = halt_q || (halt_seen && !br_taken); // A flushed HLT does not stop fetch.

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q   <= 16'h0000;
			halt_q <= 1'b0;
		end else begin
			if (br_taken) begin
				pc_q <= br_target;
			end else if (!stall && !fetch_stop) begin
				pc_q <= pc_plus2;
			end
			if (halt_seen && !br_taken) begin
				halt_q <= 1'b1;
			end
		end
	end

	imem #(.IMEM_WORDS(IMEM_WORDS)) u_imem (
		.clk(clk), .we_i(imem_we_i && rst_i), .waddr_i(imem_addr_i),
		.wdata_i(imem_data_i), .addr_i(pc_q), .data_o(instr)
	);

	assign ifid_d = '{instr: instr, pc2: pc_plus2};

	stage_reg #(.PAYLOAD_T(ifid_t), .BUBBLE(IFID_BUBBLE)) u_ifid (
		.clk(clk), .rst_i(rst_i), .hold_i(stall),
		.flush_i(br_taken || (fetch_stop && !stall)),
		.d_i(ifid_d), .q_o(ifid_q), .valid_o(ifid_valid)
	);

	// ********************
	// Decode and register file.
	decode u_decode (
		.ifid_i(ifid_q), .ifid_valid_i(ifid_valid), .rf(rf_bus.dec_mp),
		.idex_o(idex_d), .rs_o(dec_rs), .rt_o(dec_rt), .halt_seen_o(halt_seen)
	);

	reg_file u_reg_file (.clk(clk), .rst_i(rst_i), .rf(rf_bus.rf_mp));

	stage_reg #(.PAYLOAD_T(idex_t), .BUBBLE(IDEX_BUBBLE)) u_idex (
		.clk(clk), .rst_i(rst_i), .hold_i(1'b0), .flush_i(stall || br_taken),
		.d_i(idex_d), .q_o(idex_q), .valid_o(idex_valid)
	);

	hazard_fwd u_hazard_fwd (
		.dec_rs_i(dec_rs), .dec_rt_i(dec_rt),
		.ex_op_i(idex_q.op), .ex_rd_i(idex_q.rd), .ex_rs_i(idex_q.rs), .ex_rt_i(idex_q.rt),
		.mem_op_i(exmem_q.op), .mem_rd_i(exmem_q.rd),
		.wb_op_i(memwb_q.op), .wb_rd_i(memwb_q.rd),
		.stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
	);

	// ********************
	// Execute and memory.
	execute u_execute (
		.clk(clk), .rst_i(rst_i), .idex_i(idex_q), .idex_valid_i(idex_valid),
		.fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_fwd_i(exmem_q.result), .wb_fwd_i(wb_value),
		.exmem_o(exmem_d), .br_taken_o(br_taken), .br_target_o(br_target)
	);

	stage_reg #(.PAYLOAD_T(exmem_t), .BUBBLE(EXMEM_BUBBLE)) u_exmem (
		.clk(clk), .rst_i(rst_i), .hold_i(1'b0), .flush_i(1'b0),
		.d_i(exmem_d), .q_o(exmem_q), .valid_o(exmem_valid)
	);

	assign dmem_addr_o  = exmem_q.addr;
	assign dmem_wdata_o = exmem_q.st_data;
	assign dmem_we_o    = exmem_valid && exmem_q.op == OP_SW;
	assign dmem_re_o    = exmem_valid && is_load(exmem_q.op); // Data returns next cycle.

	assign memwb_d = '{op: exmem_q.op, rd: exmem_q.rd, result: exmem_q.result};

	stage_reg #(.PAYLOAD_T(memwb_t), .BUBBLE(MEMWB_BUBBLE)) u_memwb (
		.clk(clk), .rst_i(rst_i), .hold_i(1'b0), .flush_i(1'b0),
		.d_i(memwb_d), .q_o(memwb_q), .valid_o(memwb_valid)
	);

	// ********************
	// Write-back.
	assign wb_value      = is_load(memwb_q.op) ? dmem_rdata_i : memwb_q.result;
	assign rf_bus.we     = memwb_valid && writes_reg(memwb_q.op);
	assign rf_bus.waddr  = memwb_q.rd;
	assign rf_bus.wdata  = wb_value;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			hlt_q <= 1'b0;
		end else if (exmem_valid && exmem_q.op == OP_HLT) begin
			hlt_q <= 1'b1; // Rises as HLT enters write-back.
		end
	end

	assign hlt_o = hlt_q;
	assign pc_o  = pc_q;

endmodule

// ==== bench/cpu_tb_progs.svh ====
`ifndef CPU_TB_PROGS_SVH
`define CPU_TB_PROGS_SVH

localparam int NUM_TESTS = 6;

typedef struct packed {
	logic [0:15][15:0] prog;
	logic [2:0]        n_stores;
	logic [0:3][15:0]  exp_addr;
	logic [0:3][15:0]  exp_data;
} test_row_t;

string test_name [NUM_TESTS] = '{
	"llb_lhb_constant", "alu_lcg_flags", "alu_forwarding",
	"load_use_stall", "branches", "halt"
};

// ********************
// Unused program words are HLT.
test_row_t tests [NUM_TESTS] = '{
	'{prog: '{16'hA134, 16'hB112, 16'h9103, 16'hB2AB, 16'hA2CD, 16'h9204, 16'hF000, 16'hF000,
		16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		n_stores: 3'd2, exp_addr: '{16'd3, 16'd4, 16'd0, 16'd0},
		exp_data: '{16'h1234, 16'hABCD, 16'h0000, 16'h0000}},
	'{prog: '{16'hA100, 16'hB100, 16'hA200, 16'hB200, 16'h0312, 16'h1412, 16'h2512, 16'h9300,
		16'h9401, 16'h9502, 16'h1612, 16'hC201, 16'h9103, 16'hC001, 16'h9204, 16'hF000},
		n_stores: 3'd4, exp_addr: '{16'd0, 16'd1, 16'd2, 16'd3}, // Operands filled in at start.
		exp_data: '{16'h0000, 16'h0000, 16'h0000, 16'h0000}},
	'{prog: '{16'hA105, 16'hA203, 16'h0312, 16'h0433, 16'h1541, 16'h2653, 16'h9364, 16'h9600,
		16'h9501, 16'h9402, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		n_stores: 3'd4, exp_addr: '{16'd7, 16'd0, 16'd1, 16'd2},
		exp_data: '{16'h0008, 16'h0003, 16'h000B, 16'h0010}},
	'{prog: '{16'hA17B, 16'hB12A, 16'h9105, 16'h8205, 16'h0321, 16'h9306, 16'h8406, 16'h0542,
		16'h9507, 16'h9404, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		n_stores: 3'd4, exp_addr: '{16'd5, 16'd6, 16'd7, 16'd4},
		exp_data: '{16'h2A7B, 16'h54F6, 16'h7F71, 16'h54F6}},
	'{prog: '{16'hA111, 16'h2211, 16'hC202, 16'h9100, 16'h9101, 16'h9102, 16'h0311, 16'hC201,
		16'h9303, 16'hCE01, 16'h9304, 16'hC001, 16'h9106, 16'h9305, 16'hF000, 16'hF000},
		n_stores: 3'd3, exp_addr: '{16'd2, 16'd3, 16'd5, 16'd0}, // Stores at 0, 1, 4, 6 skipped.
		exp_data: '{16'h0011, 16'h0022, 16'h0022, 16'h0000}},
	'{prog: '{16'hA166, 16'h9100, 16'hF000, 16'h9101, 16'h9102, 16'hA177, 16'h9103, 16'hF000,
		16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		n_stores: 3'd1, exp_addr: '{16'd0, 16'd0, 16'd0, 16'd0},
		exp_data: '{16'h0066, 16'h0000, 16'h0000, 16'h0000}}
};

`endif

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

	localparam int IMEM_WORDS   = 256;
	localparam int AW           = $clog2(IMEM_WORDS);
	localparam int HALT_TIMEOUT = 300;
	localparam int HOLD_CYCLES  = 20;
	localparam logic [31:0] LCG_SEED = 32'd84;

	logic          clk = 1'b0;
	logic          rst_i;
	logic          imem_we;
	logic [AW-1:0] imem_addr;
	logic [15:0]   imem_data;
	logic [15:0]   dmem_addr;
	logic [15:0]   dmem_wdata;
	logic          dmem_we;
	logic          dmem_re;
	logic [15:0]   dmem_rdata = 16'h0000;
	logic [15:0]   pc;
	logic          hlt;

	logic [15:0]   dmem [256];
	logic [15:0]   store_addr [$];
	logic [15:0]   store_data [$];
	int            errors = 0;
	int            test_errs = 0;
	int            passed = 0;
	int            failed_tests = 0;

	`include "cpu_tb_progs.svh"

	cpu #(.IMEM_WORDS(IMEM_WORDS)) i_cpu (
		.clk(clk), .rst_i(rst_i),
		.imem_we_i(imem_we), .imem_addr_i(imem_addr), .imem_data_i(imem_data),
		.dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
		.dmem_re_o(dmem_re), .dmem_rdata_i(dmem_rdata),
		.pc_o(pc), .hlt_o(hlt)
	);

	always #2 clk = ~clk;

	// ********************
	// Data memory model with one cycle of read latency.
	always @(posedge clk) begin
		if (rst_i) begin
			for (int a = 0; a < 256; a++) begin
				dmem[a] <= fill_word(8'(a));
			end
			store_addr.delete();
			store_data.delete();
			dmem_rdata <= 16'h0000;
		end else begin
			if (dmem_we) begin
				dmem[dmem_addr[7:0]] <= dmem_wdata;
				store_addr.push_back(dmem_addr);
				store_data.push_back(dmem_wdata);
			end
			if (dmem_re) begin
				dmem_rdata <= dmem[dmem_addr[7:0]];
			end
		end
	end

	function automatic logic [15:0] fill_word(input logic [7:0] addr);
		return {addr ^ 8'h5A, ~addr};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic note_mismatch(input string msg);
		$display("FAIL %0d ns: %s", $time, msg);
		errors++;
		test_errs++;
	endtask

	// ********************
	// Test 2 takes its operands from the LCG.
	task automatic prepare_alu_row();
		logic [31:0] state;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] diff;
		state = lcg_next(LCG_SEED);
		a     = state[31:16];
		state = lcg_next(state);
		b     = state[31:16];
		diff  = a - b;
		tests[1].prog[0][7:0] = a[7:0];
		tests[1].prog[1][7:0] = a[15:8];
		tests[1].prog[2][7:0] = b[7:0];
		tests[1].prog[3][7:0] = b[15:8];
		tests[1].exp_data[0]  = a + b;
		tests[1].exp_data[1]  = diff;
		tests[1].exp_data[2]  = a ^ b;
		if (diff == 16'h0000) begin // Z set so BR EQ skips the store at 3.
			tests[1].exp_addr[3] = 16'd4;
			tests[1].exp_data[3] = b;
		end else begin
			tests[1].exp_addr[3] = 16'd3;
			tests[1].exp_data[3] = a;
		end
	endtask

	task automatic load_program(input int t);
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			rst_i     <= 1'b1;
			imem_we   <= 1'b1;
			imem_addr <= AW'(i);
			imem_data <= tests[t].prog[i];
		end
		@(posedge clk);
		rst_i   <= 1'b0;
		imem_we <= 1'b0;
	endtask

	task automatic idle_after_reset();
		@(negedge clk);
		if (hlt !== 1'b0 || dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
			note_mismatch("hlt_o, dmem_we_o or dmem_re_o not low after reset");
		end
	endtask

	task automatic wait_for_halt(output bit halted);
		int cycles;
		cycles = 0;
		while (hlt !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		halted = (hlt === 1'b1);
		if (!halted) begin
			$display("timeout waiting for hlt_o after %0d cycles", HALT_TIMEOUT);
			errors++;
			test_errs++;
		end
	endtask

	task automatic pc_holds_after_halt();
		logic [15:0] pc_held;
		int          moved;
		pc_held = pc;
		moved   = 0;
		for (int i = 0; i < HOLD_CYCLES; i++) begin
			@(negedge clk);
			if (pc !== pc_held || hlt !== 1'b1) begin
				moved++;
			end
		end
		if (moved != 0) begin
			note_mismatch($sformatf("pc_o or hlt_o changed in %0d cycles after halt", moved));
		end
	endtask

	task automatic compare_stores(input int t);
		int n;
		n = int'(tests[t].n_stores);
		if (store_addr.size() != n) begin
			note_mismatch($sformatf("%0d stores logged, expected %0d", store_addr.size(), n));
		end
		for (int i = 0; i < n && i < store_addr.size(); i++) begin
			if (store_addr[i] !== tests[t].exp_addr[i] ||
					store_data[i] !== tests[t].exp_data[i]) begin
				note_mismatch($sformatf("store %0d wrote %h to %h, expected %h to %h", i,
					store_data[i], store_addr[i], tests[t].exp_data[i], tests[t].exp_addr[i]));
			end
		end
	endtask

	task automatic run_test(input int t);
		bit halted;
		test_errs = 0;
		load_program(t);
		idle_after_reset();
		wait_for_halt(halted);
		if (halted) begin
			pc_holds_after_halt(); // Also catches stores placed after HLT.
			compare_stores(t);
		end
		if (test_errs == 0) begin
			passed++;
			$display("test %0d %s: passed", t + 1, test_name[t]);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", t + 1, test_name[t], test_errs);
		end
	endtask

	// ********************
	initial begin
		rst_i     = 1'b1;
		imem_we   = 1'b0;
		imem_addr = '0;
		imem_data = 16'h0000;
		prepare_alu_row();
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d failed checks",
			NUM_TESTS, passed, failed_tests, errors);
		if (failed_tests == 0 && errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+bench
src/cpu_pkg.sv
src/rf_if.sv
src/stage_reg.sv
src/reg_file.sv
src/decode.sv
src/hazard_fwd.sv
src/execute.sv
src/imem.sv
src/cpu.sv
bench/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cpu_tb -f files.f -o cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
